// ==== source/spw_pkg.sv ====
//--------------------------------------------------------------------
// SpaceWire transmitter shared definitions
// Character kinds, payload views, frame format and credit limits
//--------------------------------------------------------------------

package spw_pkg;

	// Characters the transmitter can put on the line
	typedef enum logic [2:0] {
		NULL,
		FCT,
		DATA,
		EOP,
		EEP
	} char_kind_t;

	// Control character codes sent high bit first
	localparam logic [1:0] FCT_CODE = 2'b00;
	localparam logic [1:0] EOP_CODE = 2'b01;
	localparam logic [1:0] EEP_CODE = 2'b10;
	localparam logic [1:0] ESC_CODE = 2'b11;

	// Credit handling
	localparam int CREDIT_PER_FCT = 8;
	localparam logic [2:0] FCT_PENDING_MAX = 3'd7;

	typedef struct packed {
		logic [5:0] unused;
		logic [1:0] code;
	} ctrl_view_t;

	// Same 8 bits read as a data byte or as a control code
	typedef union packed {
		logic [7:0] data;
		ctrl_view_t ctrl;
	} char_payload_u;

	typedef struct packed {
		char_kind_t kind;
		char_payload_u payload;
	} char_req_t;

	// Bit 0 leaves first
	typedef struct packed {
		logic [9:0] bits;
		logic [3:0] len;
	} frame_t;

	// Host side character with flag set for EOP or EEP
	typedef struct packed {
		logic flag;
		logic [7:0] data;
	} data_char_t;

endpackage

// ==== source/tx_link_fsm.sv ====
//--------------------------------------------------------------------
// Link start sequencer
// Steps through start, NULL, NULL/FCT and full traffic, and picks
// the next character by priority whenever the encoder asks
//--------------------------------------------------------------------

`timescale 1ns/1ns

module tx_link_fsm
	import spw_pkg::*;
(
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic       send_null_i,
	input  logic       send_fct_i,
	input  logic       txwrite_i,
	input  data_char_t data_i,
	input  logic       pick_i,
	input  logic       has_credit_i,
	input  logic       fct_pending_i,
	output char_req_t  req_o,
	output logic       req_valid_o,
	output logic       ready_o,
	output logic       data_used_o,
	output logic       fct_used_o
);

	typedef enum logic [1:0] {
		ST_START,
		ST_NULL,
		ST_NULL_FCT,
		ST_FULL
	} link_state_t;

	link_state_t state_q;
	link_state_t state_d;
	logic        send_fct;
	logic        send_data;

	always_comb
	begin
		state_d = state_q;
		req_valid_o = 1'b1;
		send_fct = 1'b0;
		send_data = 1'b0;

		case (state_q)
			ST_START:
			begin
				req_valid_o = 1'b0;
				if (send_null_i)
					state_d = ST_NULL;
			end
			ST_NULL:
			begin
				if (send_null_i && send_fct_i)
					state_d = ST_NULL_FCT;
			end
			ST_NULL_FCT:
			begin
				send_fct = fct_pending_i;
				if (send_fct_i && has_credit_i)
					state_d = ST_FULL;
			end
			default:
			begin
				// FCT first, then an N-char if credit allows
				if (fct_pending_i)
					send_fct = 1'b1;
				else if (txwrite_i && has_credit_i)
					send_data = 1'b1;
			end
		endcase
	end

	// NULL carries the code of its trailing FCT
	always_comb
	begin
		req_o = '0;
		req_o.kind = NULL;
		req_o.payload.ctrl.code = FCT_CODE;

		if (send_fct)
		begin
			req_o.kind = FCT;
		end
		else if (send_data)
		begin
			if (!data_i.flag)
			begin
				req_o.kind = DATA;
				req_o.payload.data = data_i.data;
			end
			else if (data_i.data[0])
			begin
				req_o.kind = EEP;
				req_o.payload.ctrl.code = EEP_CODE;
			end
			else
			begin
				req_o.kind = EOP;
				req_o.payload.ctrl.code = EOP_CODE;
			end
		end
	end

	assign ready_o = pick_i && send_data;
	assign data_used_o = pick_i && send_data;
	assign fct_used_o = pick_i && send_fct;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			state_q <= ST_START;
		else if (pick_i)
			state_q <= state_d;
	end

endmodule

// ==== source/tx_flow_credit.sv ====
//--------------------------------------------------------------------
// Flow control credit keeper
// Outgoing N-char credit from received FCTs, and FCTs owed to the
// far end for local buffer space
//--------------------------------------------------------------------

`timescale 1ns/1ns

module tx_flow_credit
	import spw_pkg::*;
#(
	parameter int CREDIT_MAX = 56
)
(
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic gotfct_i,
	input  logic send_fct_now_i,
	input  logic data_used_i,
	input  logic fct_used_i,
	output logic has_credit_o,
	output logic fct_pending_o
);

	localparam int CW = $clog2(CREDIT_MAX + 1);

	logic [CW-1:0] credit_q;
	logic [CW:0]   credit_sum;
	logic [2:0]    pending_q;

	// One bit wider so the add cannot wrap before the clamp
	always_comb
	begin
		credit_sum = {1'b0, credit_q};
		if (gotfct_i)
			credit_sum = credit_sum + (CW+1)'(CREDIT_PER_FCT);
		if (data_used_i)
			credit_sum = credit_sum - (CW+1)'(1);
		if (credit_sum > (CW+1)'(CREDIT_MAX))
			credit_sum = (CW+1)'(CREDIT_MAX);
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit_q <= '0;
			pending_q <= '0;
		end
		else
		begin
			credit_q <= credit_sum[CW-1:0];
			if (send_fct_now_i && !fct_used_i && pending_q != FCT_PENDING_MAX)
				pending_q <= pending_q + 3'd1;
			else if (fct_used_i && !send_fct_now_i)
				pending_q <= pending_q - 3'd1;
		end
	end

	assign has_credit_o = (credit_q != '0);
	assign fct_pending_o = (pending_q != 3'd0);

endmodule

// ==== source/tx_char_encoder.sv ====
//--------------------------------------------------------------------
// Character encoder
// Frames one character with its parity bit and holds it until the
// shifter takes it
//--------------------------------------------------------------------

`timescale 1ns/1ns

module tx_char_encoder
	import spw_pkg::*;
(
	input  logic      pclk_tx,
	input  logic      enable_tx,
	input  char_req_t req_i,
	input  logic      req_valid_i,
	input  logic      take_i,
	output logic      pick_o,
	output frame_t    frame_o,
	output logic      full_o
);

	frame_t        frame_q;
	frame_t        frame_d;
	logic          full_q;
	char_payload_u prev_q;
	logic          prev_data_q;
	logic          prev_par;
	logic          flag;
	logic          par;

	assign pick_o = !full_q || take_i;
	assign full_o = full_q;
	assign frame_o = frame_q;

	// Parity covers the previous payload and the current flag
	always_comb
	begin
		prev_par = prev_data_q ? ^prev_q.data : ^prev_q.ctrl.code;
		flag = (req_i.kind != DATA);
		par = ~(flag ^ prev_par);

		case (req_i.kind)
			DATA:
				frame_d = '{bits: {req_i.payload.data, 1'b0, par}, len: 4'd10};
			NULL:
				// ESC then FCT with inner parity 0
				frame_d = '{bits: {2'b00, FCT_CODE[0], FCT_CODE[1], 1'b1, 1'b0,
				                   ESC_CODE[0], ESC_CODE[1], 1'b1, par},
				            len: 4'd8};
			default:
				frame_d = '{bits: {6'd0, req_i.payload.ctrl.code[0],
				                   req_i.payload.ctrl.code[1], 1'b1, par},
				            len: 4'd4};
		endcase
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			full_q <= 1'b0;
			prev_q.ctrl <= '{unused: 6'd0, code: FCT_CODE};
			prev_data_q <= 1'b0;
		end
		else if (pick_o)
		begin
			full_q <= req_valid_i;
			if (req_valid_i)
			begin
				prev_q <= req_i.payload;
				prev_data_q <= (req_i.kind == DATA);
			end
		end
	end

	always_ff @(posedge pclk_tx)
	begin
		if (pick_o && req_valid_i)
			frame_q <= frame_d;
	end

endmodule

// ==== source/tx_ds_shifter.sv ====
//--------------------------------------------------------------------
// DS shifter
// Sends frames one bit per clock and toggles strobe on repeated bits
//--------------------------------------------------------------------

`timescale 1ns/1ns

module tx_ds_shifter
	import spw_pkg::*;
(
	input  logic   pclk_tx,
	input  logic   enable_tx,
	input  frame_t frame_i,
	input  logic   full_i,
	output logic   take_o,
	output logic   tx_dout_o,
	output logic   tx_sout_o
);

	logic [8:0] shift_q;
	logic [3:0] left_q;
	logic       shifting;
	logic       next_bit;

	// left_q counts bits still to send after the one on the line
	assign shifting = (left_q != 4'd0);
	assign take_o = full_i && !shifting;
	assign next_bit = take_o ? frame_i.bits[0] : shift_q[0];

	always_ff @(posedge pclk_tx)
	begin
		if (take_o)
			shift_q <= frame_i.bits[9:1];
		else if (shifting)
			shift_q <= {1'b0, shift_q[8:1]};
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			left_q <= 4'd0;
			tx_dout_o <= 1'b0;
			tx_sout_o <= 1'b0;
		end
		else if (take_o || shifting)
		begin
			left_q <= take_o ? frame_i.len - 4'd1 : left_q - 4'd1;
			tx_dout_o <= next_bit;
			// Strobe changes only when data does not
			if (next_bit == tx_dout_o)
				tx_sout_o <= ~tx_sout_o;
		end
	end

endmodule

// ==== source/spw_tx_top.sv ====
//--------------------------------------------------------------------
// SpaceWire transmitter top level
// Link sequencer, credit keeper, character encoder and DS shifter
//--------------------------------------------------------------------

`timescale 1ns/1ns

module spw_tx_top
	import spw_pkg::*;
#(
	parameter int CREDIT_MAX = 56
)
(
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic       send_null_i,
	input  logic       send_fct_i,
	input  data_char_t data_i,
	input  logic       txwrite_i,
	input  logic       gotfct_i,
	input  logic       send_fct_now_i,
	output logic       tx_dout_o,
	output logic       tx_sout_o,
	output logic       ready_o
);

	char_req_t req;
	frame_t    frame;
	logic      req_valid;
	logic      pick;
	logic      take;
	logic      frame_full;
	logic      has_credit;
	logic      fct_pending;
	logic      data_used;
	logic      fct_used;

	tx_link_fsm tx_link_fsm_inst (
		.pclk_tx       (pclk_tx),
		.enable_tx     (enable_tx),
		.send_null_i   (send_null_i),
		.send_fct_i    (send_fct_i),
		.txwrite_i     (txwrite_i),
		.data_i        (data_i),
		.pick_i        (pick),
		.has_credit_i  (has_credit),
		.fct_pending_i (fct_pending),
		.req_o         (req),
		.req_valid_o   (req_valid),
		.ready_o       (ready_o),
		.data_used_o   (data_used),
		.fct_used_o    (fct_used)
	);

	tx_flow_credit #(
		.CREDIT_MAX (CREDIT_MAX)
	) tx_flow_credit_inst (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.gotfct_i       (gotfct_i),
		.send_fct_now_i (send_fct_now_i),
		.data_used_i    (data_used),
		.fct_used_i     (fct_used),
		.has_credit_o   (has_credit),
		.fct_pending_o  (fct_pending)
	);

	tx_char_encoder tx_char_encoder_inst (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.req_i       (req),
		.req_valid_i (req_valid),
		.take_i      (take),
		.pick_o      (pick),
		.frame_o     (frame),
		.full_o      (frame_full)
	);

	tx_ds_shifter tx_ds_shifter_inst (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.frame_i   (frame),
		.full_i    (frame_full),
		.take_o    (take),
		.tx_dout_o (tx_dout_o),
		.tx_sout_o (tx_sout_o)
	);

endmodule

// ==== dv/spw_tx_props.sv ====
//----------------------------------------------------------------------
// SpaceWire transmitter line properties
// DS encoding, ready pulse width and quiet line in reset
//----------------------------------------------------------------------

`timescale 1ns/1ns

module spw_tx_props (
	input logic pclk_tx,
	input logic enable_tx,
	input logic tx_dout_o,
	input logic tx_sout_o,
	input logic ready_o
);

	logic started_q;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			started_q <= 1'b0;
		else if (tx_dout_o || tx_sout_o)
			started_q <= 1'b1;
	end

	one_line_changes: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		started_q |-> ((tx_dout_o != $past(tx_dout_o)) != (tx_sout_o != $past(tx_sout_o))))
		else $error("DS pair did not change exactly one line");

	ready_single_pulse: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_o |=> !ready_o)
		else $error("ready_o high for two cycles");

	quiet_in_reset: assert property (@(posedge pclk_tx)
		!enable_tx |=> (!tx_dout_o && !tx_sout_o && !ready_o))
		else $error("line active while enable_tx low");

endmodule

bind spw_tx_top spw_tx_props spw_tx_props_inst (
	.pclk_tx   (pclk_tx),
	.enable_tx (enable_tx),
	.tx_dout_o (tx_dout_o),
	.tx_sout_o (tx_sout_o),
	.ready_o   (ready_o)
);

// ==== dv/spw_tx_tb.sv ====
//----------------------------------------------------------------------
// SpaceWire transmitter testbench
// Directed tests with a DS bit-stream decoder that checks parity
//----------------------------------------------------------------------

`timescale 1ns/1ns

module spw_tx_tb
	import spw_pkg::*;
();

	// Longest test sends about 30 characters of up to 10 bits
	localparam int TIMEOUT_CYCLES = 4000;

	logic       pclk_tx;
	logic       enable_tx;
	logic       send_null_i;
	logic       send_fct_i;
	data_char_t data_i;
	logic       txwrite_i;
	logic       gotfct_i;
	logic       send_fct_now_i;
	logic       tx_dout_o;
	logic       tx_sout_o;
	logic       ready_o;

	int error_count = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int ready_count = 0;
	int cycle_count = 0;

	// Decoder state
	logic          line_started = 1'b0;
	logic          prev_d = 1'b0;
	logic          prev_s = 1'b0;
	int            rx_cnt = 0;
	logic          rx_par = 1'b0;
	logic          rx_flag = 1'b0;
	logic          rx_prev_xor = 1'b0;
	logic          rx_esc = 1'b0;
	logic [7:0]    rx_data = '0;
	logic [1:0]    rx_code = '0;
	char_kind_t    rx_kind_q[$];
	char_payload_u rx_pay_q[$];

	spw_tx_top spw_tx_top_inst (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.send_null_i    (send_null_i),
		.send_fct_i     (send_fct_i),
		.data_i         (data_i),
		.txwrite_i      (txwrite_i),
		.gotfct_i       (gotfct_i),
		.send_fct_now_i (send_fct_now_i),
		.tx_dout_o      (tx_dout_o),
		.tx_sout_o      (tx_sout_o),
		.ready_o        (ready_o)
	);

	always #4 pclk_tx = ~pclk_tx;

	always @(posedge pclk_tx)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still going after %0d cycles", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------
	task automatic check_kind(input string what, input char_kind_t exp, input char_kind_t got);
		if (exp != got)
		begin
			$display("[FAIL] %0t %s: expected %s, got %s", $time, what, exp.name(), got.name());
			error_count++;
		end
	endtask

	task automatic check_payload(input string what, input char_payload_u exp,
			input char_payload_u got);
		if (exp != got)
		begin
			$display("[FAIL] %0t %s: expected %h, got %h", $time, what, exp.data, got.data);
			error_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic got);
		if (exp !== got)
		begin
			$display("[FAIL] %0t %s: expected %b, got %b", $time, what, exp, got);
			error_count++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int got);
		if (exp != got)
		begin
			$display("[FAIL] %0t %s: expected %0d, got %0d", $time, what, exp, got);
			error_count++;
		end
	endtask

	function automatic char_payload_u ctrl_payload(input logic [1:0] code);
		char_payload_u p;
		p = '0;
		p.ctrl.code = code;
		return p;
	endfunction

	function automatic char_payload_u data_payload(input logic [7:0] b);
		char_payload_u p;
		p.data = b;
		return p;
	endfunction

	// ------------------------------------------------------------------
	// DS decoder
	// ------------------------------------------------------------------
	task automatic push_char(input char_kind_t kind, input char_payload_u pay);
		rx_kind_q.push_back(kind);
		rx_pay_q.push_back(pay);
	endtask

	task automatic end_char();
		rx_cnt = 0;
		if (!rx_flag)
		begin
			rx_prev_xor = ^rx_data;
			push_char(DATA, data_payload(rx_data));
		end
		else
		begin
			rx_prev_xor = ^rx_code;
			if (rx_esc)
			begin
				rx_esc = 1'b0;
				if (rx_code == FCT_CODE)
					push_char(NULL, ctrl_payload(FCT_CODE));
				else
				begin
					$display("%0t: escape followed by code %b instead of an FCT", $time, rx_code);
					error_count++;
				end
			end
			else if (rx_code == ESC_CODE)
				rx_esc = 1'b1;
			else if (rx_code == FCT_CODE)
				push_char(FCT, ctrl_payload(rx_code));
			else if (rx_code == EOP_CODE)
				push_char(EOP, ctrl_payload(rx_code));
			else
				push_char(EEP, ctrl_payload(rx_code));
		end
	endtask

	task automatic decode_bit(input logic b);
		rx_cnt++;
		if (rx_cnt == 1)
			rx_par = b;
		else if (rx_cnt == 2)
		begin
			rx_flag = b;
			// Odd parity over previous payload, this parity bit and flag
			check_bit("parity bit", ~(b ^ rx_prev_xor), rx_par);
		end
		else if (rx_flag)
			rx_code = {rx_code[0], b};
		else
			rx_data = {b, rx_data[7:1]};

		if ((rx_flag && rx_cnt == 4) || (!rx_flag && rx_cnt == 10))
			end_char();
	endtask

	always @(negedge pclk_tx)
	begin
		if (enable_tx)
		begin
			if (ready_o)
				ready_count++;
			if (line_started)
			begin
				if ((tx_dout_o != prev_d) == (tx_sout_o != prev_s))
				begin
					$display("%0t: DS pair broke the one-line-changes rule", $time);
					error_count++;
				end
				decode_bit(tx_dout_o);
			end
			else if (tx_dout_o || tx_sout_o)
			begin
				line_started = 1'b1;
				decode_bit(tx_dout_o);
			end
			prev_d = tx_dout_o;
			prev_s = tx_sout_o;
		end
	end

	// ------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------
	task automatic read_char(output char_kind_t kind, output char_payload_u pay);
		while (rx_kind_q.size() == 0)
			@(posedge pclk_tx);
		kind = rx_kind_q.pop_front();
		pay = rx_pay_q.pop_front();
	endtask

	task automatic read_past_nulls(output char_kind_t kind, output char_payload_u pay);
		read_char(kind, pay);
		while (kind == NULL)
			read_char(kind, pay);
	endtask

	// Returns just after the edge that captured data_i
	task automatic wait_ready();
		@(negedge pclk_tx);
		while (!ready_o)
			@(negedge pclk_tx);
		@(posedge pclk_tx);
	endtask

	task automatic expect_nulls(input int count);
		char_kind_t    kind;
		char_payload_u pay;
		repeat (count)
		begin
			read_char(kind, pay);
			check_kind("decoded kind", NULL, kind);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_bad++;
			$display("test %0d %s: %0d errors", tests_run, name, error_count - errs_before);
		end
	endtask

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------
	task automatic test_reset_and_nulls();
		int   errs;
		int   waited;
		logic started;
		errs = error_count;
		repeat (4)
		begin
			@(negedge pclk_tx);
			check_bit("tx_dout_o", 1'b0, tx_dout_o);
			check_bit("tx_sout_o", 1'b0, tx_sout_o);
			check_bit("ready_o", 1'b0, ready_o);
		end
		@(posedge pclk_tx);
		enable_tx <= 1'b1;
		// Line stays quiet in the start state
		repeat (5)
		begin
			@(negedge pclk_tx);
			check_bit("tx_dout_o", 1'b0, tx_dout_o);
			check_bit("tx_sout_o", 1'b0, tx_sout_o);
			check_bit("ready_o", 1'b0, ready_o);
		end
		@(posedge pclk_tx);
		send_null_i <= 1'b1;
		waited = 0;
		started = 1'b0;
		while (!started && waited < 4)
		begin
			@(negedge pclk_tx);
			waited++;
			started = tx_dout_o || tx_sout_o;
		end
		if (!started)
		begin
			$display("%0t: no bit on the line within 4 cycles of send_null_i", $time);
			error_count++;
		end
		expect_nulls(6);
		finish_test("reset_and_nulls", errs);
	endtask

	task automatic test_fct_strobes();
		char_kind_t    kind;
		char_payload_u pay;
		int            errs;
		int            fct_seen;
		int            n;
		errs = error_count;
		@(posedge pclk_tx);
		send_fct_i <= 1'b1;
		rx_kind_q.delete();
		rx_pay_q.delete();
		repeat (3)
		begin
			@(posedge pclk_tx);
			send_fct_now_i <= 1'b1;
			@(posedge pclk_tx);
			send_fct_now_i <= 1'b0;
			repeat (2) @(posedge pclk_tx);
		end
		fct_seen = 0;
		n = 0;
		while (fct_seen < 3 && n < 30)
		begin
			read_char(kind, pay);
			n++;
			if (kind == FCT)
				fct_seen++;
			else
				check_kind("decoded kind", NULL, kind);
		end
		check_count("FCT characters", 3, fct_seen);
		expect_nulls(6);
		finish_test("fct_strobes", errs);
	endtask

	task automatic test_no_credit();
		int errs;
		int r0;
		errs = error_count;
		@(posedge pclk_tx);
		data_i <= '{flag: 1'b0, data: 8'($urandom)};
		txwrite_i <= 1'b1;
		r0 = ready_count;
		expect_nulls(10);
		check_count("ready_o pulses", r0, ready_count);
		finish_test("no_credit", errs);
	endtask

	task automatic test_data_with_credit();
		logic [7:0]    bytes[8];
		char_kind_t    kind;
		char_payload_u pay;
		int            errs;
		int            r0;
		errs = error_count;
		foreach (bytes[i])
			bytes[i] = 8'($urandom);
		@(posedge pclk_tx);
		data_i <= '{flag: 1'b0, data: bytes[0]};
		gotfct_i <= 1'b1;
		@(posedge pclk_tx);
		gotfct_i <= 1'b0;
		r0 = ready_count;
		for (int i = 0; i < 8; i++)
		begin
			wait_ready();
			data_i <= '{flag: 1'b0, data: (i < 7) ? bytes[i + 1] : 8'($urandom)};
		end
		read_past_nulls(kind, pay);
		for (int i = 0; i < 8; i++)
		begin
			if (i > 0)
				read_char(kind, pay);
			check_kind("decoded kind", DATA, kind);
			check_payload("decoded byte", data_payload(bytes[i]), pay);
		end
		// Out of credit while txwrite_i stays high
		expect_nulls(4);
		check_count("ready_o pulses", 8, ready_count - r0);
		finish_test("data_with_credit", errs);
	endtask

	task automatic test_eop_eep();
		char_kind_t    kind;
		char_payload_u pay;
		logic [7:0]    last;
		int            errs;
		errs = error_count;
		last = 8'($urandom);
		@(posedge pclk_tx);
		data_i <= '{flag: 1'b1, data: 8'h00};
		gotfct_i <= 1'b1;
		@(posedge pclk_tx);
		gotfct_i <= 1'b0;
		wait_ready();
		data_i <= '{flag: 1'b1, data: 8'h01};
		wait_ready();
		data_i <= '{flag: 1'b0, data: last};
		wait_ready();
		txwrite_i <= 1'b0;
		read_past_nulls(kind, pay);
		check_kind("decoded kind", EOP, kind);
		read_char(kind, pay);
		check_kind("decoded kind", EEP, kind);
		read_char(kind, pay);
		check_kind("decoded kind", DATA, kind);
		check_payload("decoded byte", data_payload(last), pay);
		expect_nulls(2);
		finish_test("eop_eep", errs);
	endtask

	initial
	begin
		pclk_tx = 1'b0;
		enable_tx = 1'b0;
		send_null_i = 1'b0;
		send_fct_i = 1'b0;
		data_i = '0;
		txwrite_i = 1'b0;
		gotfct_i = 1'b0;
		send_fct_now_i = 1'b0;
		void'($urandom(32'h78ed7337));

		test_reset_and_nulls();
		test_fct_strobes();
		test_no_credit();
		test_data_with_credit();
		test_eop_eep();

		$display("%0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_bad, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== all.f ====
source/spw_pkg.sv
source/tx_link_fsm.sv
source/tx_flow_credit.sv
source/tx_char_encoder.sv
source/tx_ds_shifter.sv
source/spw_tx_top.sv
dv/spw_tx_props.sv
dv/spw_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the SpaceWire transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module spw_tx_tb -o spw_tx_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/spw_tx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
